//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and address width
`define CPU_WORD_WIDTH 32
// memory data width
`define CPU_BUS_WIDTH 16

`define CPU_REG_ADDR_WIDTH 5
`define CPU_REG_COUNT 32

// pc after reset
`define CPU_BOOT_PC 32'hffc00000

// cycles counted per fetch parcel
`define CPU_BUS_WAIT 3

`endif

//--- source/isa_pkg.sv
`default_nettype none
`include "cpu_settings.svh"

package isa_pkg;
    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [`CPU_BUS_WIDTH-1:0] half_t;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [7:0] opcode_t;
    typedef logic [3:0] ccr_t; // {carry, negative, overflow, zero}

    // ir[15:13]
    typedef enum logic [2:0] {
        AM_INH = 3'h0,
        AM_IMM = 3'h1,
        AM_REG = 3'h3,
        AM_DIR = 3'h4,
        AM_PCIND = 3'h5
    } addr_mode_t;

    typedef enum logic [2:0] {
        ALU_AND = 3'h0,
        ALU_OR = 3'h1,
        ALU_ADD = 3'h2,
        ALU_SUB = 3'h3,
        ALU_XOR = 3'h4,
        ALU_PASS = 3'h5 // 6 and 7 pass as well
    } alu_func_t;

    localparam int CCR_C = 3;
    localparam int CCR_N = 2;
    localparam int CCR_V = 1;
    localparam int CCR_Z = 0;

    localparam opcode_t OP_ALU = 8'h00; // low 3 bits select the function
    localparam opcode_t OP_MOV = 8'h10;
    localparam opcode_t OP_CMP = 8'h11;
    localparam opcode_t OP_INC = 8'h13;
    localparam opcode_t OP_DEC = 8'h14;
    localparam opcode_t OP_LDI = 8'h20; // imm mode
    localparam opcode_t OP_BRA = 8'h20; // pcind mode
    localparam opcode_t OP_BEQ = 8'h21;
    localparam opcode_t OP_BNE = 8'h22;
    localparam opcode_t OP_BRN = 8'h2c;
    localparam opcode_t OP_STL = 8'h20; // dir mode
    localparam opcode_t OP_LDL = 8'h21;
    localparam opcode_t OP_JMP = 8'h50;
endpackage

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;
    typedef enum logic [3:0] {
        ST_FETCH1,
        ST_EVAL1,
        ST_FETCH2,
        ST_EVAL2,
        ST_FETCH3,
        ST_EVAL3,
        ST_STORE,
        ST_STORE2,
        ST_STORE3,
        ST_LOAD,
        ST_LOAD2,
        ST_LOAD3,
        ST_LOAD4,
        ST_PCWAIT,
        ST_FAULT
    } cpu_state_t;

    typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

    typedef enum logic {MDR_HIGH, MDR_LOW} mdr_sel_t;

    typedef enum logic [2:0] {
        DEST_IR,
        DEST_MDR_LO, // shifts mdr up by one parcel
        DEST_MAR_OFS, // sign-extended branch offset
        DEST_MAR_HI,
        DEST_MAR_LO
    } parcel_dest_t;
endpackage

`default_nettype wire

//--- source/bus_wait_timer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module bus_wait_timer (
    input wire clk,
    input wire rst_n,
    input wire wait_start,
    output logic wait_done
);
    localparam int CW = $clog2(`CPU_BUS_WAIT + 1);

    logic [CW-1:0] count; // 0 when idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wait_start) begin
            count <= CW'(`CPU_BUS_WAIT);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign wait_done = (count == CW'(1)); // last cycle of the parcel
endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input wire isa_pkg::alu_func_t func,
    input wire isa_pkg::word_t in1,
    input wire isa_pkg::word_t in2,
    output isa_pkg::word_t result,
    output isa_pkg::ccr_t flags
);
    import isa_pkg::*;

    localparam int MSB = $bits(word_t) - 1;

    logic carry, overflow;

    always_comb begin
        carry = 1'b0;
        overflow = 1'b0;
        case (func)
            ALU_AND: result = in1 & in2;
            ALU_OR: result = in1 | in2;
            ALU_ADD: begin
                {carry, result} = {1'b0, in1} + {1'b0, in2};
                overflow = (in1[MSB] == in2[MSB]) && (result[MSB] != in1[MSB]);
            end
            ALU_SUB: begin
                {carry, result} = {1'b0, in1} - {1'b0, in2}; // carry is borrow
                overflow = (in1[MSB] != in2[MSB]) && (result[MSB] != in1[MSB]);
            end
            ALU_XOR: result = in1 ^ in2;
            default: result = in1; // pass rB
        endcase
    end

    always_comb begin
        flags[CCR_C] = carry;
        flags[CCR_N] = result[MSB];
        flags[CCR_V] = overflow;
        flags[CCR_Z] = (result == '0);
    end
endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module register_file (
    input wire clk,
    input wire rst_n,
    input wire isa_pkg::reg_addr_t rd_addr1,
    input wire isa_pkg::reg_addr_t rd_addr2,
    output isa_pkg::word_t rd_data1,
    output isa_pkg::word_t rd_data2,
    input wire isa_pkg::reg_addr_t wr_addr,
    input wire wr_en,
    input wire isa_pkg::word_t wr_data
);
    import isa_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data; // whole word only
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
endmodule

`default_nettype wire

//--- source/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_datapath (
    input wire clk,
    input wire rst_n,
    input wire isa_pkg::half_t data_in,
    input wire parcel_load,
    input wire core_pkg::parcel_dest_t parcel_dest,
    input wire pc_load,
    input wire isa_pkg::word_t pc_value,
    input wire mar_load,
    input wire isa_pkg::word_t mar_value,
    input wire mdr_load,
    input wire isa_pkg::word_t mdr_value,
    input wire core_pkg::addr_sel_t addr_sel,
    input wire core_pkg::mdr_sel_t mdr_sel,
    input wire ccr_load,
    input wire isa_pkg::ccr_t ccr_in,
    output isa_pkg::word_t addrbus,
    output isa_pkg::half_t data_out,
    output isa_pkg::half_t ir,
    output isa_pkg::word_t pc,
    output isa_pkg::word_t mar,
    output isa_pkg::word_t mdr,
    output isa_pkg::ccr_t ccr
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int HW = $bits(half_t);
    localparam int WW = $bits(word_t);

    word_t offset;

    assign offset = {{(WW - HW){data_in[HW-1]}}, data_in};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_BOOT_PC;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
            ccr <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_value;
            end else if (parcel_load) begin
                pc <= pc + word_t'(2);
            end
            if (parcel_load) begin
                case (parcel_dest)
                    DEST_MDR_LO: mdr <= {mdr[HW-1:0], data_in};
                    DEST_MAR_OFS: mar <= offset;
                    DEST_MAR_HI: mar <= {data_in, mar[HW-1:0]};
                    DEST_MAR_LO: mar <= {mar[WW-1:HW], data_in};
                    default: ir <= data_in; // opcode parcel
                endcase
            end
            if (mar_load) begin
                mar <= mar_value;
            end
            if (mdr_load) begin
                mdr <= mdr_value;
            end
            if (ccr_load) begin
                ccr <= ccr_in;
            end
        end
    end

    assign addrbus = (addr_sel == ADDR_MAR) ? mar : pc;
    assign data_out = (mdr_sel == MDR_HIGH) ? mdr[WW-1:HW] : mdr[HW-1:0];
endmodule

`default_nettype wire

//--- source/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
    input wire clk,
    input wire rst_n,
    input wire wait_done,
    input wire isa_pkg::half_t ir,
    input wire isa_pkg::half_t data_in,
    input wire isa_pkg::word_t pc,
    input wire isa_pkg::word_t mar,
    input wire isa_pkg::word_t mdr,
    input wire isa_pkg::ccr_t ccr,
    input wire isa_pkg::word_t alu_result,
    input wire isa_pkg::word_t rd_data1,
    input wire isa_pkg::word_t rd_data2,
    output logic wait_start,
    output logic parcel_load,
    output core_pkg::parcel_dest_t parcel_dest,
    output logic pc_load,
    output isa_pkg::word_t pc_value,
    output logic mar_load,
    output isa_pkg::word_t mar_value,
    output logic mdr_load,
    output isa_pkg::word_t mdr_value,
    output core_pkg::addr_sel_t addr_sel,
    output core_pkg::mdr_sel_t mdr_sel,
    output logic write_out,
    output logic ccr_load,
    output isa_pkg::reg_addr_t rd_addr1,
    output isa_pkg::reg_addr_t rd_addr2,
    output isa_pkg::reg_addr_t wr_addr,
    output logic wr_en,
    output isa_pkg::word_t wr_data,
    output isa_pkg::alu_func_t alu_func,
    output isa_pkg::word_t alu_in1,
    output isa_pkg::word_t alu_in2
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int HW = $bits(half_t);
    localparam int WW = $bits(word_t);

    cpu_state_t state, state_next;
    logic fetching, fetching_next; // timer running for this parcel
    addr_sel_t addr_sel_next;
    mdr_sel_t mdr_sel_next;
    logic write_out_next;
    addr_mode_t mode;
    opcode_t op;
    reg_addr_t ra, rb, rc;

    assign mode = addr_mode_t'(ir[15:13]);
    assign op = ir[12:5];
    assign ra = ir[4:0];
    assign rb = mdr[12:8]; // second parcel
    assign rc = mdr[4:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FETCH1;
            fetching <= 1'b0;
            addr_sel <= ADDR_PC;
            mdr_sel <= MDR_LOW;
            write_out <= 1'b0;
        end else begin
            state <= state_next;
            fetching <= fetching_next;
            addr_sel <= addr_sel_next;
            mdr_sel <= mdr_sel_next;
            write_out <= write_out_next;
        end
    end

    always_comb begin
        state_next = state;
        fetching_next = fetching;
        addr_sel_next = addr_sel;
        mdr_sel_next = mdr_sel;
        write_out_next = write_out;
        wait_start = 1'b0;
        parcel_load = 1'b0;
        parcel_dest = DEST_IR;
        pc_load = 1'b0;
        pc_value = mar;
        mar_load = 1'b0;
        mar_value = alu_result;
        mdr_load = 1'b0;
        mdr_value = rd_data1;
        ccr_load = 1'b0;
        rd_addr1 = ra;
        rd_addr2 = rb;
        wr_addr = ra;
        wr_en = 1'b0;
        wr_data = alu_result;
        alu_func = ALU_PASS;
        alu_in1 = rd_data1;
        alu_in2 = rd_data2;
        case (state)
            ST_FETCH1, ST_FETCH2, ST_FETCH3: begin
                if (state == ST_FETCH2) begin
                    case (mode)
                        AM_PCIND: parcel_dest = DEST_MAR_OFS;
                        AM_DIR: parcel_dest = DEST_MAR_HI;
                        default: parcel_dest = DEST_MDR_LO;
                    endcase
                end else if (state == ST_FETCH3) begin
                    parcel_dest = (mode == AM_DIR) ? DEST_MAR_LO : DEST_MDR_LO;
                end
                if (!fetching) begin
                    wait_start = 1'b1;
                    fetching_next = 1'b1;
                end else if (wait_done) begin
                    parcel_load = 1'b1;
                    fetching_next = 1'b0;
                    case (state)
                        ST_FETCH1: state_next = ST_EVAL1;
                        ST_FETCH2: state_next = ST_EVAL2;
                        default: state_next = ST_EVAL3;
                    endcase
                end
            end
            ST_EVAL1: begin
                if (mode == AM_REG && (op == OP_INC || op == OP_DEC)) begin
                    alu_func = (op == OP_INC) ? ALU_ADD : ALU_SUB;
                    alu_in2 = word_t'(1);
                    wr_en = 1'b1;
                    state_next = ST_FETCH1;
                end else if (mode inside {AM_IMM, AM_REG, AM_DIR, AM_PCIND}) begin
                    state_next = ST_FETCH2;
                end else begin
                    state_next = ST_FAULT;
                end
            end
            ST_EVAL2: begin
                state_next = ST_FETCH1;
                case (mode)
                    AM_REG: begin
                        if (op[7:3] == OP_ALU[7:3]) begin // rA = rB op rC
                            rd_addr1 = rb;
                            rd_addr2 = rc;
                            alu_func = alu_func_t'(op[2:0]);
                            wr_en = 1'b1;
                        end else if (op == OP_MOV) begin
                            rd_addr1 = rb;
                            wr_data = rd_data1;
                            wr_en = 1'b1;
                        end else if (op == OP_CMP) begin
                            alu_func = ALU_SUB; // rA - rB
                            ccr_load = 1'b1;
                        end else begin
                            state_next = ST_FAULT;
                        end
                    end
                    AM_PCIND: begin
                        alu_func = ALU_ADD;
                        alu_in1 = pc;
                        alu_in2 = mar; // sign-extended offset
                        pc_value = alu_result;
                        state_next = ST_PCWAIT;
                        case (op)
                            OP_BRA: pc_load = 1'b1;
                            OP_BEQ: pc_load = ccr[CCR_Z];
                            OP_BNE: pc_load = !ccr[CCR_Z];
                            OP_BRN: pc_load = 1'b0;
                            default: state_next = ST_FAULT;
                        endcase
                    end
                    AM_IMM, AM_DIR: state_next = ST_FETCH3;
                    default: state_next = ST_FAULT;
                endcase
            end
            ST_EVAL3: begin
                state_next = ST_FAULT;
                if (mode == AM_IMM && op == OP_LDI) begin
                    wr_data = mdr;
                    wr_en = 1'b1;
                    state_next = ST_FETCH1;
                end else if (mode == AM_DIR) begin
                    case (op)
                        OP_STL: begin
                            mdr_load = 1'b1; // rA
                            mdr_sel_next = MDR_HIGH;
                            addr_sel_next = ADDR_MAR;
                            write_out_next = 1'b1;
                            state_next = ST_STORE;
                        end
                        OP_LDL: begin
                            addr_sel_next = ADDR_MAR;
                            state_next = ST_LOAD;
                        end
                        OP_JMP: begin
                            pc_load = 1'b1;
                            state_next = ST_FETCH1;
                        end
                        default: state_next = ST_FAULT;
                    endcase
                end
            end
            ST_STORE: begin
                write_out_next = 1'b0;
                state_next = ST_STORE2;
            end
            ST_STORE2: begin
                alu_func = ALU_ADD;
                alu_in1 = mar;
                alu_in2 = word_t'(2);
                mar_load = 1'b1;
                mdr_sel_next = MDR_LOW;
                write_out_next = 1'b1;
                state_next = ST_STORE3;
            end
            ST_STORE3: begin
                write_out_next = 1'b0;
                addr_sel_next = ADDR_PC;
                state_next = ST_FETCH1;
            end
            ST_LOAD: state_next = ST_LOAD2;
            ST_LOAD2: begin
                wr_data = {data_in, half_t'(0)}; // high half first
                wr_en = 1'b1;
                alu_func = ALU_ADD;
                alu_in1 = mar;
                alu_in2 = word_t'(2);
                mar_load = 1'b1;
                state_next = ST_LOAD3;
            end
            ST_LOAD3: state_next = ST_LOAD4;
            ST_LOAD4: begin
                wr_data = {rd_data1[WW-1:HW], data_in};
                wr_en = 1'b1;
                addr_sel_next = ADDR_PC;
                state_next = ST_FETCH1;
            end
            ST_PCWAIT: state_next = ST_FETCH1;
            default: state_next = ST_FAULT; // never left
        endcase
    end
endmodule

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input wire clk,
    input wire rst_n,
    output isa_pkg::word_t addrbus,
    input wire isa_pkg::half_t data_in,
    output isa_pkg::half_t data_out,
    output logic write_out,
    output isa_pkg::ccr_t ccr
);
    import isa_pkg::*;
    import core_pkg::*;

    logic wait_start, wait_done;
    logic parcel_load, pc_load, mar_load, mdr_load, ccr_load, wr_en;
    parcel_dest_t parcel_dest;
    addr_sel_t addr_sel;
    mdr_sel_t mdr_sel;
    word_t pc_value, mar_value, mdr_value;
    word_t pc, mar, mdr;
    half_t ir;
    reg_addr_t rd_addr1, rd_addr2, wr_addr;
    word_t rd_data1, rd_data2, wr_data;
    alu_func_t alu_func;
    word_t alu_in1, alu_in2, alu_result;
    ccr_t alu_flags;

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .wait_done(wait_done),
        .ir(ir), .data_in(data_in), .pc(pc), .mar(mar), .mdr(mdr), .ccr(ccr),
        .alu_result(alu_result), .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wait_start(wait_start), .parcel_load(parcel_load), .parcel_dest(parcel_dest),
        .pc_load(pc_load), .pc_value(pc_value),
        .mar_load(mar_load), .mar_value(mar_value),
        .mdr_load(mdr_load), .mdr_value(mdr_value),
        .addr_sel(addr_sel), .mdr_sel(mdr_sel), .write_out(write_out), .ccr_load(ccr_load),
        .rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .wr_addr(wr_addr),
        .wr_en(wr_en), .wr_data(wr_data),
        .alu_func(alu_func), .alu_in1(alu_in1), .alu_in2(alu_in2)
    );

    bus_wait_timer u_timer (
        .clk(clk), .rst_n(rst_n), .wait_start(wait_start), .wait_done(wait_done)
    );

    cpu_datapath u_datapath (
        .clk(clk), .rst_n(rst_n), .data_in(data_in),
        .parcel_load(parcel_load), .parcel_dest(parcel_dest),
        .pc_load(pc_load), .pc_value(pc_value),
        .mar_load(mar_load), .mar_value(mar_value),
        .mdr_load(mdr_load), .mdr_value(mdr_value),
        .addr_sel(addr_sel), .mdr_sel(mdr_sel),
        .ccr_load(ccr_load), .ccr_in(alu_flags),
        .addrbus(addrbus), .data_out(data_out),
        .ir(ir), .pc(pc), .mar(mar), .mdr(mdr), .ccr(ccr)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wr_addr(wr_addr), .wr_en(wr_en), .wr_data(wr_data)
    );

    alu u_alu (
        .func(alu_func), .in1(alu_in1), .in2(alu_in2),
        .result(alu_result), .flags(alu_flags)
    );
endmodule

`default_nettype wire

//--- verification/memory_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module memory_model #(
    parameter int INDEX_BITS = 12 // halfwords held, upper address bits ignored
) (
    input wire clk,
    input wire [`CPU_WORD_WIDTH-1:0] addr,
    input wire [`CPU_BUS_WIDTH-1:0] wdata,
    input wire write,
    output logic [`CPU_BUS_WIDTH-1:0] rdata,
    input wire load_en,
    input wire [`CPU_WORD_WIDTH-1:0] load_addr,
    input wire [`CPU_BUS_WIDTH-1:0] load_data
);
    logic [`CPU_BUS_WIDTH-1:0] ram [2**INDEX_BITS];
    logic [INDEX_BITS-1:0] index;

    assign index = addr[INDEX_BITS:1]; // halfword index

    always @(posedge clk) begin
        if (load_en) begin
            ram[load_addr[INDEX_BITS:1]] <= load_data; // program loading
        end else if (write) begin
            ram[index] <= wdata;
        end
        rdata <= ram[index]; // one cycle read latency
    end
endmodule

`default_nettype wire

//--- verification/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb;
    localparam int WW = `CPU_WORD_WIDTH;
    localparam int HW = `CPU_BUS_WIDTH;
    localparam logic [WW-1:0] BOOT = `CPU_BOOT_PC;
    localparam logic [WW-1:0] DATA = 32'h0001_0800; // data area
    localparam logic [WW-1:0] REGION = 32'h100; // per test
    localparam logic [WW-1:0] END_VALUE = 32'hc0de_0e4d;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 4000;

    localparam logic [2:0] MODE_IMM = 3'd1;
    localparam logic [2:0] MODE_REG = 3'd3;
    localparam logic [2:0] MODE_DIR = 3'd4;
    localparam logic [2:0] MODE_PCIND = 3'd5;

    localparam logic [7:0] OP_MOV = 8'h10;
    localparam logic [7:0] OP_CMP = 8'h11;
    localparam logic [7:0] OP_INC = 8'h13;
    localparam logic [7:0] OP_DEC = 8'h14;
    localparam logic [7:0] OP_LDI = 8'h20;
    localparam logic [7:0] OP_BRA = 8'h20;
    localparam logic [7:0] OP_BEQ = 8'h21;
    localparam logic [7:0] OP_BNE = 8'h22;
    localparam logic [7:0] OP_BRN = 8'h2c;
    localparam logic [7:0] OP_STL = 8'h20;
    localparam logic [7:0] OP_LDL = 8'h21;
    localparam logic [7:0] OP_JMP = 8'h50;

    logic clk = 1'b0;
    logic rst_n;
    logic [WW-1:0] addrbus;
    logic [HW-1:0] data_in;
    logic [HW-1:0] data_out;
    logic write_out;
    logic [3:0] ccr;
    logic load_en;
    logic [WW-1:0] load_addr;
    logic [HW-1:0] load_data;

    logic [HW-1:0] prog [$];
    logic [HW-1:0] written [logic [WW-1:0]]; // last halfword seen per address
    int write_count = 0;
    integer seed = 32'h223;

    cpu_top dut (
        .clk(clk), .rst_n(rst_n), .addrbus(addrbus), .data_in(data_in),
        .data_out(data_out), .write_out(write_out), .ccr(ccr)
    );

    memory_model mem (
        .clk(clk), .addr(addrbus), .wdata(data_out), .write(write_out), .rdata(data_in),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && write_out) begin // taken by memory at next edge
            written[addrbus] = data_out;
            write_count = write_count + 1;
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Program never finished: no final store within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_stored(input logic [WW-1:0] addr, input logic [31:0] expected,
                                input string what);
        check(written.exists(addr) && written.exists(addr + 2), 1, {what, " was written"});
        check({written[addr], written[addr + 2]}, expected, what); // high half first
    endtask

    function automatic logic [31:0] expected_alu(input logic [2:0] func,
                                                 input logic [31:0] b, input logic [31:0] c);
        case (func)
            3'd0: return b & c;
            3'd1: return b | c;
            3'd2: return b + c;
            3'd3: return b - c;
            3'd4: return b ^ c;
            default: return b;
        endcase
    endfunction

    // {carry, negative, overflow, zero} of a - b
    function automatic logic [3:0] sub_flags(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] diff;
        longint wide;
        diff = a - b;
        wide = longint'($signed(a)) - longint'($signed(b));
        return {a < b, diff[31], wide != longint'($signed(diff)), diff == 0};
    endfunction

    function automatic logic branch_taken(input logic [7:0] op, input logic zero);
        case (op)
            OP_BRA: return 1'b1;
            OP_BEQ: return zero;
            OP_BNE: return !zero;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [HW-1:0] opword(input logic [2:0] mode, input logic [7:0] op,
                                             input logic [4:0] ra);
        return {mode, op, ra};
    endfunction

    task automatic ldi_to(input logic [4:0] ra, input logic [31:0] value);
        prog.push_back(opword(MODE_IMM, OP_LDI, ra));
        prog.push_back(value[31:16]);
        prog.push_back(value[15:0]);
    endtask

    task automatic alu_op(input logic [2:0] func, input logic [4:0] ra,
                          input logic [4:0] rb, input logic [4:0] rc);
        prog.push_back(opword(MODE_REG, {5'b0, func}, ra));
        prog.push_back({3'b0, rb, 3'b0, rc});
    endtask

    task automatic two_reg_op(input logic [7:0] op, input logic [4:0] ra, input logic [4:0] rb);
        prog.push_back(opword(MODE_REG, op, ra));
        prog.push_back({3'b0, rb, 8'b0});
    endtask

    task automatic one_reg_op(input logic [7:0] op, input logic [4:0] ra);
        prog.push_back(opword(MODE_REG, op, ra));
    endtask

    task automatic branch_by(input logic [7:0] op, input logic [15:0] offset);
        prog.push_back(opword(MODE_PCIND, op, 5'd0));
        prog.push_back(offset); // from the address after the offset
    endtask

    task automatic direct_op(input logic [7:0] op, input logic [4:0] ra,
                             input logic [WW-1:0] addr);
        prog.push_back(opword(MODE_DIR, op, ra));
        prog.push_back(addr[31:16]);
        prog.push_back(addr[15:0]);
    endtask

    task automatic finish_program(input logic [WW-1:0] base);
        ldi_to(5'd31, END_VALUE);
        direct_op(OP_STL, 5'd31, base + 32'hf8);
        branch_by(OP_BRA, 16'hfffc); // spin on itself
    endtask

    // marker at addr when not taken and at addr+8 when taken
    task automatic branch_case(input logic [7:0] op, input logic [WW-1:0] addr);
        branch_by(op, 16'd10);
        direct_op(OP_STL, 5'd1, addr);
        branch_by(OP_BRA, 16'd6);
        direct_op(OP_STL, 5'd1, addr + 8);
    endtask

    task automatic check_path(input logic [WW-1:0] addr, input logic taken, input string what);
        check(written.exists(addr), !taken, {what, " fall-through marker"});
        check(written.exists(addr + 8), taken, {what, " target marker"});
    endtask

    task automatic load_and_start;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= BOOT + 32'(2 * i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        prog.delete();
    endtask

    task automatic wait_for_write(input logic [WW-1:0] addr);
        while (!written.exists(addr)) begin
            @(posedge clk);
        end
    endtask

    task automatic run_to_end(input logic [WW-1:0] base);
        load_and_start();
        wait_for_write(base + 32'hfa);
        check_stored(base + 32'hf8, END_VALUE, "final marker");
    endtask

    task automatic test_store_load;
        logic [WW-1:0] base;
        logic [31:0] value;
        base = DATA + REGION;
        value = $random(seed);
        ldi_to(5'd1, value);
        direct_op(OP_STL, 5'd1, base);
        direct_op(OP_LDL, 5'd2, base);
        direct_op(OP_STL, 5'd2, base + 16);
        finish_program(base);
        run_to_end(base);
        check_stored(base, value, "st.l of ldi value");
        check_stored(base + 16, value, "st.l after ld.l");
        check(ccr, 0, "ccr without cmp");
    endtask

    task automatic test_alu;
        logic [WW-1:0] base;
        logic [31:0] b;
        logic [31:0] c;
        base = DATA + 2 * REGION;
        b = $random(seed);
        c = $random(seed);
        ldi_to(5'd1, b);
        ldi_to(5'd2, c);
        for (int f = 0; f < 8; f++) begin
            alu_op(f[2:0], 5'(3 + f), 5'd1, 5'd2);
            direct_op(OP_STL, 5'(3 + f), base + 32'(8 * f));
        end
        finish_program(base);
        run_to_end(base);
        for (int f = 0; f < 8; f++) begin
            check_stored(base + 32'(8 * f), expected_alu(f[2:0], b, c),
                         $sformatf("alu function %0d", f));
        end
    endtask

    task automatic test_inc_dec_mov;
        logic [WW-1:0] base;
        logic [31:0] value;
        base = DATA + 3 * REGION;
        value = $random(seed);
        ldi_to(5'd1, value);
        one_reg_op(OP_INC, 5'd1);
        direct_op(OP_STL, 5'd1, base);
        one_reg_op(OP_DEC, 5'd1);
        one_reg_op(OP_DEC, 5'd1);
        direct_op(OP_STL, 5'd1, base + 8);
        two_reg_op(OP_MOV, 5'd2, 5'd1);
        one_reg_op(OP_INC, 5'd1); // copy stays behind
        direct_op(OP_STL, 5'd2, base + 16);
        direct_op(OP_STL, 5'd1, base + 24);
        ldi_to(5'd3, 32'hffff_ffff);
        one_reg_op(OP_INC, 5'd3);
        direct_op(OP_STL, 5'd3, base + 32);
        ldi_to(5'd4, 32'h0);
        one_reg_op(OP_DEC, 5'd4);
        direct_op(OP_STL, 5'd4, base + 40);
        finish_program(base);
        run_to_end(base);
        check_stored(base, value + 1, "inc");
        check_stored(base + 8, value - 1, "dec twice");
        check_stored(base + 16, value - 1, "mov copy");
        check_stored(base + 24, value, "inc after mov");
        check_stored(base + 32, 32'h0, "inc wraps to zero");
        check_stored(base + 40, 32'hffff_ffff, "dec wraps from zero");
    endtask

    task automatic test_branches;
        logic [WW-1:0] base;
        logic [31:0] a;
        logic [31:0] b;
        logic zero;
        base = DATA + 4 * REGION;
        a = $random(seed);
        b = $random(seed);
        if (a == b) begin
            b = a ^ 32'h1;
        end
        zero = (a == b);
        ldi_to(5'd1, a);
        ldi_to(5'd2, b);
        two_reg_op(OP_CMP, 5'd1, 5'd1); // equal operands
        branch_case(OP_BEQ, base);
        branch_case(OP_BNE, base + 16);
        two_reg_op(OP_CMP, 5'd1, 5'd2);
        branch_case(OP_BEQ, base + 32);
        branch_case(OP_BNE, base + 48);
        branch_case(OP_BRA, base + 64);
        branch_case(OP_BRN, base + 80);
        finish_program(base);
        run_to_end(base);
        check_path(base, branch_taken(OP_BEQ, 1'b1), "beq on equal");
        check_path(base + 16, branch_taken(OP_BNE, 1'b1), "bne on equal");
        check_path(base + 32, branch_taken(OP_BEQ, zero), "beq on unequal");
        check_path(base + 48, branch_taken(OP_BNE, zero), "bne on unequal");
        check_path(base + 64, branch_taken(OP_BRA, zero), "bra");
        check_path(base + 80, branch_taken(OP_BRN, zero), "brn");
        check(ccr, sub_flags(a, b), "ccr after cmp");
    endtask

    task automatic test_jump_fault;
        logic [WW-1:0] base;
        logic [WW-1:0] target;
        logic [31:0] value;
        int count;
        base = DATA + 5 * REGION;
        value = $random(seed);
        ldi_to(5'd5, value);
        target = BOOT + 32'(2 * (prog.size() + 6)); // past jmp and skipped store
        direct_op(OP_JMP, 5'd0, target);
        direct_op(OP_STL, 5'd5, base);
        direct_op(OP_STL, 5'd5, base + 8);
        prog.push_back(16'h0000); // undefined in inherent mode
        direct_op(OP_STL, 5'd5, base + 16);
        finish_program(base);
        load_and_start();
        wait_for_write(base + 10);
        count = write_count;
        repeat (200) @(posedge clk);
        check_stored(base + 8, value, "store at jmp target");
        check(written.exists(base), 0, "store skipped by jmp");
        check(written.exists(base + 16), 0, "store after undefined opcode");
        check(write_count, count, "writes after fault");
    endtask

    initial begin
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_store_load();
        test_alu();
        test_inc_dec_mov();
        test_branches();
        test_jump_fault();
        $display("Testbench passed");
        $finish;
    end
endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/isa_pkg.sv
source/core_pkg.sv
source/bus_wait_timer.sv
source/alu.sv
source/register_file.sv
source/cpu_datapath.sv
source/cpu_control.sv
source/cpu_top.sv
verification/memory_model.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build cpu_tb with Verilator, run it into a log and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary -Wno-fatal --top-module cpu_tb -f all.f -Mdir "$BUILD_DIR" -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/cpu_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
